// File: logic/cpu_macros.svh
/*
 * Build-time sizes for the pipelined core and its shared memory.
 * Include wherever memory depth, register count or the halt encoding is needed.
 */
`ifndef CPU_MACROS_SVH
`define CPU_MACROS_SVH

// Words in the unified instruction/data memory
`define CPU_MEM_WORDS 1024

// Architectural registers
`define CPU_NUM_REGS 32

// Opcode that stops the core once it retires
`define CPU_HALT_OP 6'b111111

`endif

// File: logic/cpuPkg.sv
/*
 * Types shared by the core, the memory arbiter and the testbench.
 * Modules import it inside their bodies and use scoped names on ports.
 */
`include "cpu_macros.svh"

package cpuPkg;

	typedef logic [31:0] word_t;
	typedef logic [$clog2(`CPU_NUM_REGS)-1:0] regIdx_t;

	// Primary opcode field, inst[31:26]
	typedef enum logic [5:0] {
		OP_RTYPE = 6'b000000,
		OP_BEQ   = 6'b000100,
		OP_BNE   = 6'b000101,
		OP_BGTZ  = 6'b000111,
		OP_ADDI  = 6'b001000,
		OP_LW    = 6'b100011,
		OP_SW    = 6'b101011,
		OP_HALT  = `CPU_HALT_OP
	} opcode_t;

	// Standard MIPS function codes, inst[5:0] of R-type
	typedef enum logic [5:0] {
		FN_SLL  = 6'b000000,
		FN_ADD  = 6'b100000,
		FN_ADDU = 6'b100001,
		FN_SUB  = 6'b100010,
		FN_SUBU = 6'b100011,
		FN_AND  = 6'b100100,
		FN_OR   = 6'b100101,
		FN_SLT  = 6'b101010,
		FN_SLTU = 6'b101011
	} funct_t;

	// ALU control encoding
	// 3 is the signed compare and 7 the unsigned one
	typedef enum logic [2:0] {
		ALU_AND  = 3'd0,
		ALU_OR   = 3'd1,
		ALU_ADD  = 3'd2,
		ALU_SLT  = 3'd3,
		ALU_ADDU = 3'd4,
		ALU_SLL  = 3'd5,
		ALU_SUB  = 3'd6,
		ALU_SLTU = 3'd7
	} aluOp_t;

	// Owner of the shared memory port
	typedef enum logic [1:0] {
		GNT_NONE,
		GNT_DATA,
		GNT_FETCH,
		GNT_EXT
	} grant_t;

endpackage

// File: logic/instDecoder.sv
/*
 * Instruction decoder for the pipeline's decode stage.
 * Turns one instruction word into an ALU operation and the control flags
 * that travel with it down the pipeline. Unknown encodings act as no-ops.
 */
`timescale 1ns/1ps

module instDecoder (
	input  cpuPkg::word_t  inst,
	output cpuPkg::aluOp_t aluOp,
	output logic           regWr,
	output logic           regDst,
	output logic           aluSrc,
	output logic           extSigned,
	output logic           memWr,
	output logic           memToReg,
	output logic           isBeq,
	output logic           isBne,
	output logic           isBgtz,
	output logic           isHalt,
	output logic           usesRt
);
	import cpuPkg::*;

	always_comb begin
		aluOp     = ALU_ADD;
		regWr     = 1'b0;
		regDst    = 1'b0;
		aluSrc    = 1'b0;
		extSigned = 1'b0;
		memWr     = 1'b0;
		memToReg  = 1'b0;
		isBeq     = 1'b0;
		isBne     = 1'b0;
		isBgtz    = 1'b0;
		isHalt    = 1'b0;
		usesRt    = 1'b0;

		case (opcode_t'(inst[31:26]))
			OP_RTYPE: begin
				regWr  = 1'b1;
				regDst = 1'b1;
				usesRt = 1'b1;
				case (funct_t'(inst[5:0]))
					FN_ADD:  aluOp = ALU_ADD;
					FN_ADDU: aluOp = ALU_ADDU;
					// No trap on overflow, so both subtracts are the same
					FN_SUB, FN_SUBU: aluOp = ALU_SUB;
					FN_AND:  aluOp = ALU_AND;
					FN_OR:   aluOp = ALU_OR;
					FN_SLL:  aluOp = ALU_SLL;
					FN_SLT:  aluOp = ALU_SLT;
					FN_SLTU: aluOp = ALU_SLTU;
					default: begin
						regWr  = 1'b0;
						regDst = 1'b0;
						usesRt = 1'b0;
					end
				endcase
			end
			OP_ADDI: begin
				regWr     = 1'b1;
				aluSrc    = 1'b1;
				extSigned = 1'b1;
			end
			OP_LW: begin
				regWr     = 1'b1;
				aluSrc    = 1'b1;
				extSigned = 1'b1;
				memToReg  = 1'b1;
			end
			OP_SW: begin
				memWr     = 1'b1;
				aluSrc    = 1'b1;
				extSigned = 1'b1;
				usesRt    = 1'b1;
			end
			// Branches compare by subtraction
			// The offset is always signed
			OP_BEQ: begin
				aluOp     = ALU_SUB;
				extSigned = 1'b1;
				isBeq     = 1'b1;
				usesRt    = 1'b1;
			end
			OP_BNE: begin
				aluOp     = ALU_SUB;
				extSigned = 1'b1;
				isBne     = 1'b1;
				usesRt    = 1'b1;
			end
			OP_BGTZ: begin
				aluOp     = ALU_SUB;
				extSigned = 1'b1;
				isBgtz    = 1'b1;
			end
			OP_HALT: isHalt = 1'b1;
			default: ;
		endcase
	end

endmodule

// File: logic/regFile.sv
/*
 * General purpose register file, two combinational reads and one write.
 * A write-back in progress is forwarded to the read ports in the same cycle.
 */
`timescale 1ns/1ps
`include "cpu_macros.svh"

module regFile (
	input  logic            clk,
	input  logic            rst,
	input  logic            wrEn,
	input  cpuPkg::regIdx_t wrIdx,
	input  cpuPkg::regIdx_t rdIdxA,
	input  cpuPkg::regIdx_t rdIdxB,
	input  cpuPkg::word_t   wrData,
	output cpuPkg::word_t   rdDataA,
	output cpuPkg::word_t   rdDataB
);
	import cpuPkg::*;

	word_t regs [`CPU_NUM_REGS];

	always_ff @(posedge clk) begin
		if (rst) begin
			for (int i = 0; i < `CPU_NUM_REGS; i++) begin
				regs[i] <= '0;
			end
		end else if (wrEn && wrIdx != '0) begin
			regs[wrIdx] <= wrData;
		end
	end

	always_comb begin
		rdDataA = regs[rdIdxA];
		rdDataB = regs[rdIdxB];
		// Write-through
		if (wrEn && wrIdx == rdIdxA) begin
			rdDataA = wrData;
		end
		if (wrEn && wrIdx == rdIdxB) begin
			rdDataB = wrData;
		end
		// r0 is hardwired
		if (rdIdxA == '0) begin
			rdDataA = '0;
		end
		if (rdIdxB == '0) begin
			rdDataB = '0;
		end
	end

endmodule

// File: logic/alu.sv
/*
 * Execute-stage ALU.
 * Covers the logic, add/sub, shift-left and set-less-than operations,
 * with a zero flag that the branch logic uses for beq and bne.
 */
`timescale 1ns/1ps

module alu (
	input  cpuPkg::aluOp_t  op,
	input  cpuPkg::word_t   a,
	input  cpuPkg::word_t   b,
	input  cpuPkg::regIdx_t shamt,
	output cpuPkg::word_t   result,
	output logic            zero
);
	import cpuPkg::*;

	always_comb begin
		case (op)
			ALU_AND:  result = a & b;
			ALU_OR:   result = a | b;
			// Carry and overflow are not kept
			ALU_ADD, ALU_ADDU: result = a + b;
			ALU_SUB:  result = a - b;
			// sll shifts rt, rs is unused
			ALU_SLL:  result = b << shamt;
			ALU_SLT:  result = {31'b0, $signed(a) < $signed(b)};
			ALU_SLTU: result = {31'b0, a < b};
			default:  result = '0;
		endcase
	end

	assign zero = (result == '0);

endmodule

// File: logic/memArbiter.sv
/*
 * Fixed-priority arbiter in front of the single-port memory.
 * Data port beats fetch, fetch beats the external port. Each port is
 * valid/ready; read data comes back one cycle later with a one-cycle rvalid.
 */
`timescale 1ns/1ps

module memArbiter (
	input  logic          clk,
	input  logic          rst,
	input  logic          dReqValid,
	input  logic          dReqWrite,
	input  logic          fReqValid,
	input  logic          extValid,
	input  logic          extWrite,
	input  cpuPkg::word_t dReqAddr,
	input  cpuPkg::word_t dReqWData,
	input  cpuPkg::word_t fReqAddr,
	input  cpuPkg::word_t extAddr,
	input  cpuPkg::word_t extWData,
	input  cpuPkg::word_t memRData,
	output logic          dReqReady,
	output logic          dReqRValid,
	output logic          fReqReady,
	output logic          fReqRValid,
	output logic          extReady,
	output logic          extRValid,
	output logic          memEn,
	output logic          memWrite,
	output cpuPkg::word_t dReqRData,
	output cpuPkg::word_t fReqRData,
	output cpuPkg::word_t extRData,
	output cpuPkg::word_t memAddr,
	output cpuPkg::word_t memWData
);
	import cpuPkg::*;

	grant_t grant;
	grant_t readOwner;

	always_comb begin
		if (dReqValid) begin
			grant = GNT_DATA;
		end else if (fReqValid) begin
			grant = GNT_FETCH;
		end else if (extValid) begin
			grant = GNT_EXT;
		end else begin
			grant = GNT_NONE;
		end
	end

	// A port is ready whenever no higher-priority port is asking
	assign dReqReady = 1'b1;
	assign fReqReady = !dReqValid;
	assign extReady  = !dReqValid && !fReqValid;

	always_comb begin
		memEn    = (grant != GNT_NONE);
		memWrite = 1'b0;
		memAddr  = '0;
		memWData = '0;
		case (grant)
			GNT_DATA: begin
				memWrite = dReqWrite;
				memAddr  = dReqAddr;
				memWData = dReqWData;
			end
			// Fetch only reads
			GNT_FETCH: memAddr = fReqAddr;
			GNT_EXT: begin
				memWrite = extWrite;
				memAddr  = extAddr;
				memWData = extWData;
			end
			default: ;
		endcase
	end

	// Remember who issued the read so the returning word goes back to it
	always_ff @(posedge clk) begin
		if (rst) begin
			readOwner <= GNT_NONE;
		end else if (memEn && !memWrite) begin
			readOwner <= grant;
		end else begin
			readOwner <= GNT_NONE;
		end
	end

	assign dReqRValid = (readOwner == GNT_DATA);
	assign fReqRValid = (readOwner == GNT_FETCH);
	assign extRValid  = (readOwner == GNT_EXT);

	assign dReqRData = dReqRValid ? memRData : '0;
	assign fReqRData = fReqRValid ? memRData : '0;
	assign extRData  = extRValid ? memRData : '0;

endmodule

// File: logic/unifiedMem.sv
/*
 * Single-port word memory holding both program and data.
 * Takes byte addresses and drops the low two bits. Reads return one
 * cycle after the enable; writes land on the same edge.
 */
`timescale 1ns/1ps
`include "cpu_macros.svh"

module unifiedMem (
	input  logic          clk,
	input  logic          en,
	input  logic          write,
	input  cpuPkg::word_t addr,
	input  cpuPkg::word_t wData,
	output cpuPkg::word_t rData
);
	import cpuPkg::*;

	localparam int ADDR_W = $clog2(`CPU_MEM_WORDS);

	word_t mem [`CPU_MEM_WORDS];
	logic [ADDR_W-1:0] wordIdx;

	// Word index from the byte address
	assign wordIdx = addr[ADDR_W+1:2];

	always_ff @(posedge clk) begin
		if (en) begin
			if (write) begin
				mem[wordIdx] <= wData;
			end else begin
				rData <= mem[wordIdx];
			end
		end
	end

endmodule

// File: logic/cpu.sv
/*
 * Five-stage pipelined core for a MIPS integer subset, with its memory.
 * Raise run after loading a program through the ext port; halted rises
 * when the halt instruction retires. Hazards stall decode, taken branches
 * resolve in execute and flush the two younger slots.
 */
`timescale 1ns/1ps

module cpu (
	input  logic          clk,
	input  logic          rst,
	input  logic          run,
	input  logic          extValid,
	input  logic          extWrite,
	input  cpuPkg::word_t extAddr,
	input  cpuPkg::word_t extWData,
	output logic          extReady,
	output logic          extRValid,
	output logic          halted,
	output cpuPkg::word_t extRData
);
	import cpuPkg::*;

	// Fetch
	word_t pc, fetchPc, fReqRData;
	logic fReqValid, fReqReady, fReqRValid, dropResp, haltSeen, issueFetch, ifidLoad;

	// Decode
	logic ifidValid;
	word_t ifidInst, ifidPc;
	aluOp_t decAluOp;
	logic decRegWr, decRegDst, decAluSrc, decExtSigned, decMemWr, decMemToReg;
	logic decIsBeq, decIsBne, decIsBgtz, decIsHalt, decUsesRt;
	regIdx_t decRs, decRt, decDst;
	word_t decRsVal, decRtVal, decImm;
	logic hazard, idAdvance;

	// Execute
	logic idexValid, idexRegWr, idexAluSrc, idexMemWr, idexMemToReg;
	logic idexIsBeq, idexIsBne, idexIsBgtz, idexIsHalt;
	aluOp_t idexAluOp;
	regIdx_t idexDst, idexShamt;
	word_t idexPc, idexRsVal, idexRtVal, idexImm;
	word_t aluB, aluOut, branchTarget;
	logic aluZero, takeBranch;

	// Memory
	logic exmemValid, exmemRegWr, exmemMemWr, exmemMemToReg, exmemIsHalt;
	regIdx_t exmemDst;
	word_t exmemAluOut, exmemStore, dReqRData;
	logic dReqValid, dReqReady, dReqRValid, loadWait, memStall;

	// Write-back
	logic memwbValid, memwbRegWr, memwbIsHalt;
	regIdx_t memwbDst;
	word_t memwbResult;

	logic memEn, memWrite;
	word_t memAddr, memWData, memRData;

	// Only fetch when the decode slot is sure to be free when the word returns
	assign issueFetch = run && !halted && !haltSeen && !fReqValid && !fReqRValid &&
		!takeBranch && (!ifidValid || idAdvance);
	assign ifidLoad = fReqRValid && !dropResp && !takeBranch;

	always_ff @(posedge clk) begin
		if (rst) begin
			pc        <= '0;
			fReqValid <= 1'b0;
			dropResp  <= 1'b0;
		end else begin
			if (takeBranch) begin
				pc <= branchTarget;
			end else if (issueFetch) begin
				pc <= pc + 32'd4;
			end
			if (issueFetch) begin
				fReqValid <= 1'b1;
			end else if (fReqReady) begin
				fReqValid <= 1'b0;
			end
			// A wrong-path fetch already out has its word thrown away
			if (takeBranch && fReqValid) begin
				dropResp <= 1'b1;
			end else if (fReqRValid) begin
				dropResp <= 1'b0;
			end
		end
	end

	always_ff @(posedge clk) begin
		if (issueFetch) begin
			fetchPc <= pc;
		end
	end

	always_ff @(posedge clk) begin
		if (rst || takeBranch) begin
			ifidValid <= 1'b0;
		end else if (ifidLoad) begin
			ifidValid <= 1'b1;
		end else if (idAdvance) begin
			ifidValid <= 1'b0;
		end
	end

	always_ff @(posedge clk) begin
		if (ifidLoad) begin
			ifidInst <= fReqRData;
			ifidPc   <= fetchPc;
		end
	end

	instDecoder decoder_i (
		.inst(ifidInst), .aluOp(decAluOp), .regWr(decRegWr), .regDst(decRegDst),
		.aluSrc(decAluSrc), .extSigned(decExtSigned), .memWr(decMemWr),
		.memToReg(decMemToReg), .isBeq(decIsBeq), .isBne(decIsBne), .isBgtz(decIsBgtz),
		.isHalt(decIsHalt), .usesRt(decUsesRt)
	);

	assign decRs  = ifidInst[25:21];
	assign decRt  = ifidInst[20:16];
	assign decDst = decRegDst ? ifidInst[15:11] : decRt;
	assign decImm = decExtSigned ? {{16{ifidInst[15]}}, ifidInst[15:0]} : {16'b0, ifidInst[15:0]};

	regFile regFile_i (
		.clk(clk), .rst(rst), .wrEn(memwbValid && memwbRegWr), .wrIdx(memwbDst),
		.rdIdxA(decRs), .rdIdxB(decRt), .wrData(memwbResult),
		.rdDataA(decRsVal), .rdDataB(decRtVal)
	);

	// Interlock against any older writer still in flight
	// r0 never blocks
	always_comb begin
		hazard = 1'b0;
		if (idexValid && idexRegWr && idexDst != '0) begin
			hazard = hazard || idexDst == decRs || (decUsesRt && idexDst == decRt);
		end
		if (exmemValid && exmemRegWr && exmemDst != '0) begin
			hazard = hazard || exmemDst == decRs || (decUsesRt && exmemDst == decRt);
		end
		if (memwbValid && memwbRegWr && memwbDst != '0) begin
			hazard = hazard || memwbDst == decRs || (decUsesRt && memwbDst == decRt);
		end
	end

	// Nothing behind a halt may issue
	assign idAdvance = ifidValid && !hazard && !memStall && !takeBranch && !haltSeen;

	always_ff @(posedge clk) begin
		if (rst) begin
			idexValid <= 1'b0;
			haltSeen  <= 1'b0;
		end else begin
			if (!memStall) begin
				idexValid <= idAdvance;
			end
			if (idAdvance && decIsHalt) begin
				haltSeen <= 1'b1;
			end
		end
	end

	always_ff @(posedge clk) begin
		if (idAdvance) begin
			idexPc       <= ifidPc;
			idexRsVal    <= decRsVal;
			idexRtVal    <= decRtVal;
			idexImm      <= decImm;
			idexShamt    <= ifidInst[10:6];
			idexDst      <= decDst;
			idexAluOp    <= decAluOp;
			idexRegWr    <= decRegWr;
			idexAluSrc   <= decAluSrc;
			idexMemWr    <= decMemWr;
			idexMemToReg <= decMemToReg;
			idexIsBeq    <= decIsBeq;
			idexIsBne    <= decIsBne;
			idexIsBgtz   <= decIsBgtz;
			idexIsHalt   <= decIsHalt;
		end
	end

	assign aluB = idexAluSrc ? idexImm : idexRtVal;

	alu alu_i (
		.op(idexAluOp), .a(idexRsVal), .b(aluB), .shamt(idexShamt),
		.result(aluOut), .zero(aluZero)
	);

	assign branchTarget = idexPc + 32'd4 + {idexImm[29:0], 2'b00};
	assign takeBranch = idexValid && !memStall && ((idexIsBeq && aluZero) ||
		(idexIsBne && !aluZero) || (idexIsBgtz && $signed(idexRsVal) > 32'sd0));

	always_ff @(posedge clk) begin
		if (rst) begin
			exmemValid <= 1'b0;
		end else if (!memStall) begin
			exmemValid <= idexValid;
		end
	end

	always_ff @(posedge clk) begin
		if (!memStall) begin
			exmemAluOut   <= aluOut;
			exmemStore    <= idexRtVal;
			exmemDst      <= idexDst;
			exmemRegWr    <= idexRegWr;
			exmemMemWr    <= idexMemWr;
			exmemMemToReg <= idexMemToReg;
			exmemIsHalt   <= idexIsHalt;
		end
	end

	// Loads hold the pipe until their word returns
	assign dReqValid = exmemValid && (exmemMemWr || exmemMemToReg) && !loadWait;
	assign memStall  = exmemValid && ((exmemMemWr && !dReqReady) ||
		(exmemMemToReg && !dReqRValid));

	always_ff @(posedge clk) begin
		if (rst) begin
			loadWait <= 1'b0;
		end else if (dReqValid && dReqReady && !exmemMemWr) begin
			loadWait <= 1'b1;
		end else if (dReqRValid) begin
			loadWait <= 1'b0;
		end
	end

	always_ff @(posedge clk) begin
		if (rst) begin
			memwbValid <= 1'b0;
			halted     <= 1'b0;
		end else begin
			memwbValid <= exmemValid && !memStall;
			if (memwbValid && memwbIsHalt) begin
				halted <= 1'b1;
			end
		end
	end

	always_ff @(posedge clk) begin
		if (!memStall) begin
			memwbResult <= exmemMemToReg ? dReqRData : exmemAluOut;
			memwbDst    <= exmemDst;
			memwbRegWr  <= exmemRegWr;
			memwbIsHalt <= exmemIsHalt;
		end
	end

	memArbiter arbiter_i (
		.clk(clk), .rst(rst),
		.dReqValid(dReqValid), .dReqWrite(exmemMemWr), .fReqValid(fReqValid),
		.extValid(extValid), .extWrite(extWrite),
		.dReqAddr(exmemAluOut), .dReqWData(exmemStore), .fReqAddr(fetchPc),
		.extAddr(extAddr), .extWData(extWData), .memRData(memRData),
		.dReqReady(dReqReady), .dReqRValid(dReqRValid), .fReqReady(fReqReady),
		.fReqRValid(fReqRValid), .extReady(extReady), .extRValid(extRValid),
		.memEn(memEn), .memWrite(memWrite),
		.dReqRData(dReqRData), .fReqRData(fReqRData), .extRData(extRData),
		.memAddr(memAddr), .memWData(memWData)
	);

	unifiedMem mem_i (
		.clk(clk), .en(memEn), .write(memWrite),
		.addr(memAddr), .wData(memWData), .rData(memRData)
	);

endmodule

// File: testbench/cpuTb.sv
/*
 * Testbench for the pipelined core and its shared memory.
 * Each table entry holds a program, preload data and result addresses. It is
 * loaded through the ext port, run until halted, read back and compared with
 * an instruction-level model of the same ISA subset.
 */
`timescale 1ns/1ps
`include "cpu_macros.svh"

module cpuTb;
	import cpuPkg::*;

	localparam int NUM_PROGS = 4;
	localparam int MAX_INST = 40;
	localparam int MAX_DATA = 4;
	localparam int MAX_RES = 16;
	localparam int WIN_WORDS = 40;
	localparam int GUARD_WORDS = 8;
	localparam word_t WIN_BASE = 32'h200;
	localparam word_t GUARD_BASE = 32'h280;

	logic clk, rst, run, extValid, extWrite, extReady, extRValid, halted;
	word_t extAddr, extWData, extRData;

	// Program table
	word_t progMem [NUM_PROGS][MAX_INST];
	word_t dataAddr [NUM_PROGS][MAX_DATA];
	word_t dataVal [NUM_PROGS][MAX_DATA];
	word_t resAddr [NUM_PROGS][MAX_RES];
	int progLen [NUM_PROGS];
	int dataCnt [NUM_PROGS];
	int resCnt [NUM_PROGS];

	// Reference image of the shared memory
	word_t refMem [`CPU_MEM_WORDS];

	int cycles = 0;
	int cycleLimit = 0;
	int haltRises = 0;
	logic haltedLast = 1'b0;

	cpu cpu_i (
		.clk(clk), .rst(rst), .run(run), .extValid(extValid), .extWrite(extWrite),
		.extAddr(extAddr), .extWData(extWData), .extReady(extReady),
		.extRValid(extRValid), .halted(halted), .extRData(extRData)
	);

	initial begin
		clk = 1'b0;
		forever #2 clk = ~clk;
	end

	always @(posedge clk) begin
		cycles <= cycles + 1;
		if (cycleLimit > 0 && cycles >= cycleLimit) begin
			$display("Timeout: the run went past its limit of %0d cycles", cycleLimit);
			failRun();
		end
	end

	// Count rising edges of halted since the last reset
	always @(posedge clk) begin
		if (rst) begin
			haltRises <= 0;
			haltedLast <= 1'b0;
		end else begin
			if (halted && !haltedLast) begin
				haltRises <= haltRises + 1;
			end
			haltedLast <= halted;
		end
	end

	function automatic int memIdx(input word_t addr);
		return int'((addr >> 2) % `CPU_MEM_WORDS);
	endfunction

	// Background pattern that differs for every address
	function automatic word_t fillWord(input word_t addr);
		return (addr * 32'h9E37_79B1) ^ 32'h5A5A_0F0F;
	endfunction

	function automatic word_t rInst(input funct_t fn, input regIdx_t rs, input regIdx_t rt,
			input regIdx_t rd, input logic [4:0] sh);
		return {OP_RTYPE, rs, rt, rd, sh, fn};
	endfunction

	function automatic word_t iInst(input opcode_t op, input regIdx_t rs, input regIdx_t rt,
			input logic [15:0] imm);
		return {op, rs, rt, imm};
	endfunction

	task automatic addInst(input int p, input word_t w);
		progMem[p][progLen[p]] = w;
		progLen[p]++;
	endtask

	task automatic addData(input int p, input word_t addr, input word_t val);
		dataAddr[p][dataCnt[p]] = addr;
		dataVal[p][dataCnt[p]] = val;
		dataCnt[p]++;
	endtask

	task automatic addResult(input int p, input word_t addr);
		resAddr[p][resCnt[p]] = addr;
		resCnt[p]++;
	endtask

	task automatic failRun();
		$display("Errors found");
		$fatal(1, "stopping at the first failed check");
	endtask

	task automatic checkWord(input word_t got, input word_t want, input word_t addr);
		if (got !== want) begin
			$display("** Error: extRData at 0x%08h is 0x%08h, expected 0x%08h", addr, got, want);
			failRun();
		end
	endtask

	task automatic checkHalted(input logic want, input int wantRises, input string when);
		if (halted !== want || haltRises != wantRises) begin
			$display("halted is %0b with %0d rising edges %s, expected %0b with %0d",
				halted, haltRises, when, want, wantRises);
			failRun();
		end
	endtask

	task automatic buildTable();
		word_t a;
		word_t b;
		for (int p = 0; p < NUM_PROGS; p++) begin
			progLen[p] = 0;
			dataCnt[p] = 0;
			resCnt[p] = 0;
		end

		// Every ALU operation on two random operands
		a = $urandom();
		b = $urandom();
		addData(0, 32'h200, a);
		addData(0, 32'h204, b);
		addInst(0, iInst(OP_ADDI, 0, 1, 16'h0200));
		addInst(0, iInst(OP_LW, 1, 2, 16'h0000));
		addInst(0, iInst(OP_LW, 1, 3, 16'h0004));
		addInst(0, rInst(FN_ADD, 2, 3, 4, 0));
		addInst(0, rInst(FN_ADDU, 2, 3, 5, 0));
		addInst(0, rInst(FN_SUB, 2, 3, 6, 0));
		addInst(0, rInst(FN_SUBU, 3, 2, 7, 0));
		addInst(0, rInst(FN_AND, 2, 3, 8, 0));
		addInst(0, rInst(FN_OR, 2, 3, 9, 0));
		addInst(0, rInst(FN_SLL, 0, 3, 10, 7));
		addInst(0, rInst(FN_SLT, 2, 3, 11, 0));
		addInst(0, rInst(FN_SLTU, 2, 3, 12, 0));
		// Immediate of -1234
		addInst(0, iInst(OP_ADDI, 2, 13, 16'hFB2E));
		addInst(0, rInst(FN_SLT, 3, 2, 14, 0));
		for (int r = 4; r <= 14; r++) begin
			addInst(0, iInst(OP_SW, 1, r[4:0], 16'(64 + 4 * (r - 4))));
			addResult(0, WIN_BASE + 64 + 4 * (r - 4));
		end
		addInst(0, iInst(OP_HALT, 0, 0, 16'h0));

		// Dependent chains, load-use and writes to r0
		addData(1, 32'h200, $urandom());
		addInst(1, iInst(OP_ADDI, 0, 1, 16'h0200));
		addInst(1, iInst(OP_LW, 1, 2, 16'h0000));
		addInst(1, iInst(OP_ADDI, 2, 3, 16'd5));
		addInst(1, rInst(FN_ADD, 3, 3, 4, 0));
		addInst(1, rInst(FN_SUB, 4, 2, 5, 0));
		addInst(1, iInst(OP_SW, 1, 5, 16'h0040));
		addInst(1, iInst(OP_ADDI, 0, 0, 16'h0077));
		addInst(1, rInst(FN_ADD, 0, 4, 6, 0));
		addInst(1, iInst(OP_SW, 1, 6, 16'h0044));
		addInst(1, iInst(OP_SW, 1, 0, 16'h0048));
		addInst(1, iInst(OP_LW, 1, 7, 16'h0040));
		addInst(1, rInst(FN_SLL, 0, 7, 8, 2));
		addInst(1, iInst(OP_SW, 1, 8, 16'h004C));
		addInst(1, iInst(OP_HALT, 0, 0, 16'h0));
		for (int i = 0; i < 4; i++) begin
			addResult(1, WIN_BASE + 64 + 4 * i);
		end
		addResult(1, WIN_BASE);

		// Branches taken and not taken
		// The r9 stores are wrong-path markers
		addData(2, 32'h200, $urandom());
		addInst(2, iInst(OP_ADDI, 0, 1, 16'h0200));
		addInst(2, iInst(OP_ADDI, 0, 9, 16'h0BAD));
		addInst(2, iInst(OP_LW, 1, 2, 16'h0000));
		addInst(2, iInst(OP_ADDI, 2, 3, 16'h0000));
		addInst(2, iInst(OP_BEQ, 2, 3, 16'd2));
		addInst(2, iInst(OP_SW, 1, 9, 16'h0060));
		addInst(2, iInst(OP_SW, 1, 9, 16'h0064));
		addInst(2, iInst(OP_ADDI, 0, 4, 16'd1));
		addInst(2, iInst(OP_BNE, 2, 3, 16'd1));
		addInst(2, iInst(OP_ADDI, 4, 4, 16'd2));
		addInst(2, iInst(OP_SW, 1, 4, 16'h0040));
		addInst(2, iInst(OP_BNE, 4, 0, 16'd2));
		addInst(2, iInst(OP_SW, 1, 9, 16'h0068));
		addInst(2, iInst(OP_SW, 1, 9, 16'h006C));
		addInst(2, iInst(OP_BEQ, 4, 0, 16'd1));
		addInst(2, iInst(OP_ADDI, 4, 4, 16'd8));
		addInst(2, iInst(OP_SW, 1, 4, 16'h0044));
		addInst(2, iInst(OP_BGTZ, 4, 0, 16'd2));
		addInst(2, iInst(OP_SW, 1, 9, 16'h0070));
		addInst(2, iInst(OP_SW, 1, 9, 16'h0074));
		addInst(2, iInst(OP_ADDI, 0, 5, 16'hFFFF));
		addInst(2, iInst(OP_BGTZ, 5, 0, 16'd1));
		addInst(2, iInst(OP_ADDI, 4, 4, 16'd16));
		addInst(2, iInst(OP_SW, 1, 4, 16'h0048));
		// Direction depends on the sign of the random word
		addInst(2, iInst(OP_BGTZ, 2, 0, 16'd1));
		addInst(2, iInst(OP_ADDI, 4, 4, 16'd32));
		addInst(2, iInst(OP_SW, 1, 4, 16'h004C));
		addInst(2, iInst(OP_HALT, 0, 0, 16'h0));
		for (int i = 0; i < 4; i++) begin
			addResult(2, WIN_BASE + 64 + 4 * i);
		end
		for (int i = 0; i < 6; i++) begin
			addResult(2, WIN_BASE + 96 + 4 * i);
		end

		// Ext port words must survive a short run
		addData(3, 32'h200, $urandom());
		addData(3, 32'h204, $urandom());
		addData(3, 32'h208, 32'h1234_5678);
		addData(3, 32'h20C, 32'hFFFF_0000);
		addInst(3, iInst(OP_ADDI, 0, 1, 16'h0200));
		addInst(3, iInst(OP_LW, 1, 2, 16'h0008));
		addInst(3, iInst(OP_SW, 1, 2, 16'h0040));
		addInst(3, iInst(OP_HALT, 0, 0, 16'h0));
		for (int i = 0; i < 4; i++) begin
			addResult(3, WIN_BASE + 4 * i);
		end
		addResult(3, WIN_BASE + 64);
		addResult(3, WIN_BASE + 68);
	endtask

	task automatic resetDut();
		@(negedge clk);
		rst = 1'b1;
		repeat (3) @(negedge clk);
		rst = 1'b0;
	endtask

	// Both ext tasks start and end on a falling edge
	task automatic extWriteWord(input word_t addr, input word_t data);
		extValid = 1'b1;
		extWrite = 1'b1;
		extAddr = addr;
		extWData = data;
		while (!extReady) @(negedge clk);
		@(negedge clk);
		extValid = 1'b0;
		extWrite = 1'b0;
		refMem[memIdx(addr)] = data;
	endtask

	task automatic extReadWord(input word_t addr, output word_t data);
		extValid = 1'b1;
		extWrite = 1'b0;
		extAddr = addr;
		while (!extReady) @(negedge clk);
		@(negedge clk);
		extValid = 1'b0;
		if (!extRValid) begin
			$display("Read of address 0x%08h returned no data", addr);
			failRun();
		end
		data = extRData;
	endtask

	task automatic loadProgram(input int p);
		for (int i = 0; i < WIN_WORDS; i++) begin
			extWriteWord(WIN_BASE + 4 * i, fillWord(WIN_BASE + 4 * i));
		end
		for (int i = 0; i < progLen[p]; i++) begin
			extWriteWord(4 * i, progMem[p][i]);
		end
		for (int i = 0; i < dataCnt[p]; i++) begin
			extWriteWord(dataAddr[p][i], dataVal[p][i]);
		end
	endtask

	// Architectural model with no delay slot and r0 always zero
	task automatic runModel(input int p);
		word_t regs [`CPU_NUM_REGS];
		word_t pc, inst, rs, rt, imm, res;
		regIdx_t rd;
		logic wr, done;
		int steps;
		for (int i = 0; i < `CPU_NUM_REGS; i++) begin
			regs[i] = '0;
		end
		pc = '0;
		done = 1'b0;
		steps = 0;
		while (!done) begin
			inst = refMem[memIdx(pc)];
			rs = regs[inst[25:21]];
			rt = regs[inst[20:16]];
			imm = {{16{inst[15]}}, inst[15:0]};
			rd = inst[20:16];
			wr = 1'b0;
			res = '0;
			pc = pc + 32'd4;
			case (inst[31:26])
				OP_RTYPE: begin
					wr = 1'b1;
					rd = inst[15:11];
					case (inst[5:0])
						FN_ADD, FN_ADDU: res = rs + rt;
						FN_SUB, FN_SUBU: res = rs - rt;
						FN_AND: res = rs & rt;
						FN_OR: res = rs | rt;
						FN_SLL: res = rt << inst[10:6];
						FN_SLT: res = ($signed(rs) < $signed(rt)) ? 32'd1 : 32'd0;
						FN_SLTU: res = (rs < rt) ? 32'd1 : 32'd0;
						default: wr = 1'b0;
					endcase
				end
				OP_ADDI: begin
					wr = 1'b1;
					res = rs + imm;
				end
				OP_LW: begin
					wr = 1'b1;
					res = refMem[memIdx(rs + imm)];
				end
				OP_SW: refMem[memIdx(rs + imm)] = rt;
				OP_BEQ: pc = (rs == rt) ? pc + (imm << 2) : pc;
				OP_BNE: pc = (rs != rt) ? pc + (imm << 2) : pc;
				OP_BGTZ: pc = ($signed(rs) > 0) ? pc + (imm << 2) : pc;
				OP_HALT: done = 1'b1;
				default: ;
			endcase
			if (wr && rd != '0) begin
				regs[rd] = res;
			end
			steps++;
			if (steps > 4 * MAX_INST) begin
				$display("Model of program %0d never reached its halt instruction", p);
				failRun();
			end
		end
	endtask

	initial begin
		word_t got;
		rst = 1'b1;
		run = 1'b0;
		extValid = 1'b0;
		extWrite = 1'b0;
		extAddr = '0;
		extWData = '0;
		void'($urandom(2427));
		buildTable();

		// Budget for every program, its loads and its readback
		for (int p = 0; p < NUM_PROGS; p++) begin
			cycleLimit += 40 * progLen[p];
			cycleLimit += 10 * (WIN_WORDS + progLen[p] + dataCnt[p] + resCnt[p] + GUARD_WORDS);
		end

		for (int p = 0; p < NUM_PROGS; p++) begin
			resetDut();
			loadProgram(p);
			runModel(p);
			checkHalted(1'b0, 0, "before run was raised");
			run = 1'b1;
			while (!halted) @(negedge clk);
			run = 1'b0;
			for (int i = 0; i < resCnt[p]; i++) begin
				extReadWord(resAddr[p][i], got);
				checkWord(got, refMem[memIdx(resAddr[p][i])], resAddr[p][i]);
			end
			// Guard words no program touches
			for (int i = 0; i < GUARD_WORDS; i++) begin
				extReadWord(GUARD_BASE + 4 * i, got);
				checkWord(got, fillWord(GUARD_BASE + 4 * i), GUARD_BASE + 4 * i);
			end
			checkHalted(1'b1, 1, "after the results were read back");
		end

		$display("No errors");
		$finish;
	end

endmodule

// File: cpu.f
+incdir+logic
logic/cpuPkg.sv
logic/instDecoder.sv
logic/regFile.sv
logic/alu.sv
logic/memArbiter.sv
logic/unifiedMem.sv
logic/cpu.sv
testbench/cpuTb.sv

// File: Makefile
VERILATOR ?= verilator
VFLAGS    ?= --binary -j 0
TOP       ?= cpuTb
FILELIST  ?= cpu.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
PASS_MSG  := No errors

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  help   list these targets"
	@echo "  test   build the testbench with Verilator, run it and check the log"
	@echo "  clean  remove the build directory and the log"

test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD_DIR)
	-./$(BUILD_DIR)/V$(TOP) > $(LOG) 2>&1
	@cat $(LOG)
	@if grep -q "$(PASS_MSG)" $(LOG); then \
		echo "TEST PASSED"; \
	else \
		echo "TEST FAILED"; \
		exit 1; \
	fi

clean:
	rm -rf $(BUILD_DIR) $(LOG)
